// File: Makefile
TOP := tb_mc_endpoint
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f sources.f

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir $(LOG)

// File: sim/mc_endpoint_assertions.sv
module mc_endpoint_assertions import mc_pkg::*; (
  input logic         clk,
  input logic         rst_n_i,
  input logic         pready_i,
  input logic         pslverr_i,
  input mc_req_pkt_s  req_i,
  input logic         req_valid_i,
  input logic         req_ready_i,
  input mc_req_pkt_s  link_i,
  input logic         link_valid_i,
  input logic         link_ready_i,
  input mc_resp_pkt_s resp_i,
  input logic         resp_valid_i,
  input logic         resp_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [FIFO_CNT_W:0] in_flight_q;  // one spare bit to see an overflow

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_flight_q <= '0;
    end else if ((req_valid_i && req_ready_i) && !(link_valid_i && link_ready_i)) begin
      in_flight_q <= in_flight_q + 1'b1;
    end else if ((link_valid_i && link_ready_i) && !(req_valid_i && req_ready_i)) begin
      in_flight_q <= in_flight_q - 1'b1;
    end
  end

  req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else $error("req packet dropped or changed before acceptance");

  link_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    link_valid_i && !link_ready_i |=> link_valid_i && $stable(link_i))
    else $error("link packet dropped or changed before acceptance");

  resp_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
    else $error("response dropped or changed before acceptance");

  fifo_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
    in_flight_q <= FIFO_DEPTH)
    else $error("more packets in the link FIFO than it holds");

  slverr_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
    pslverr_i |-> pready_i)
    else $error("pslverr raised without pready");

endmodule

bind mc_endpoint_top mc_endpoint_assertions u_assertions (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .pready_i     (pready_o),
  .pslverr_i    (pslverr_o),
  .req_i        (req),
  .req_valid_i  (req_valid),
  .req_ready_i  (req_ready),
  .link_i       (link),
  .link_valid_i (link_valid),
  .link_ready_i (link_ready),
  .resp_i       (resp),
  .resp_valid_i (resp_valid),
  .resp_ready_i (resp_ready)
);

// File: sim/tb_mc_endpoint.sv
module tb_mc_endpoint import mc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RAND     = 24;
  localparam int NUM_OPS    = 2 * N_RAND + 40;
  localparam int POLL_LIMIT = 50;

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [DATA_W-1:0]     pwdata;
  logic [DATA_W-1:0]     prdata;
  logic                  pready;
  logic                  pslverr;

  logic [DATA_W-1:0]    ref_mem [MEM_WORDS];  // expected endpoint memory
  mc_resp_pkt_s         exp_q [$];
  logic [LOAD_ID_W-1:0] next_id;
  integer               seed;
  int                   value_errors;
  int                   other_errors;
  logic [DATA_W-1:0]    rd_data;
  logic                 rd_err;
  int                   waits;

  mc_endpoint_top UUT (
    .clk       (clk),     .rst_n_i   (rst_n),
    .psel_i    (psel),    .penable_i (penable), .pwrite_i  (pwrite),
    .paddr_i   (paddr),   .pwdata_i  (pwdata),
    .prdata_o  (prdata),  .pready_o  (pready),  .pslverr_o (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(NUM_OPS * 40 * 20);
    $display("Watchdog expired before the test sequence finished");
    $display("Some tests failed");
    $finish;
  end

  function automatic logic [DATA_W-1:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [DATA_W-1:0] in_range_addr();
    return rand_word() & DATA_W'(MEM_WORDS - 1);
  endfunction

  // entered and left 2 ns after a rising edge, outputs sampled on the falling edge
  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                          output logic err, output int nwait);
    nwait   = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      nwait++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic compare_word(input logic [DATA_W-1:0] got, exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_flag(input logic got, exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_resp(input mc_resp_pkt_s got, exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t ns: %s got id %h data %h err %b", $time, what,
               got.load_id, got.data, got.err);
      $display("   expected id %h data %h err %b", exp.load_id, exp.data, exp.err);
    end
  endtask

  task automatic store_cmd(input logic [DATA_W-1:0] addr, data);
    apb_xfer(1'b1, REG_ADDR, addr, rd_data, rd_err, waits);
    apb_xfer(1'b1, REG_DATA, data, rd_data, rd_err, waits);
    apb_xfer(1'b1, REG_CMD, DATA_W'(MC_OP_STORE), rd_data, rd_err, waits);
    if (addr[DATA_W-1:MEM_IDX_W] == '0) ref_mem[addr[MEM_IDX_W-1:0]] = data;
  endtask

  task automatic load_cmd(input logic [DATA_W-1:0] addr);
    mc_resp_pkt_s exp;
    apb_xfer(1'b1, REG_ADDR, addr, rd_data, rd_err, waits);
    apb_xfer(1'b1, REG_CMD, DATA_W'(MC_OP_LOAD), rd_data, rd_err, waits);
    exp.load_id = next_id;
    exp.err     = (addr[DATA_W-1:MEM_IDX_W] != '0);
    exp.data    = exp.err ? '0 : ref_mem[addr[MEM_IDX_W-1:0]];
    next_id++;
    exp_q.push_back(exp);
  endtask

  task automatic collect_resp(input string what);
    mc_resp_pkt_s got;
    mc_resp_pkt_s exp;
    int           polls;
    polls = 0;
    apb_xfer(1'b0, REG_STATUS, '0, rd_data, rd_err, waits);
    while (!rd_data[STAT_RESP_HELD] && polls < POLL_LIMIT) begin
      polls++;
      apb_xfer(1'b0, REG_STATUS, '0, rd_data, rd_err, waits);
    end
    if (!rd_data[STAT_RESP_HELD]) begin
      other_errors++;
      $display("No load response was held after %0d STATUS reads (%s)", POLL_LIMIT, what);
    end else if (exp_q.size() == 0) begin
      other_errors++;
      $display("A load response was held although no load was outstanding");
    end else begin
      got.err     = rd_data[STAT_RESP_ERR];
      got.load_id = UUT.u_loader.resp_q.load_id;  // tag never reaches the bus
      apb_xfer(1'b0, REG_RESP, '0, rd_data, rd_err, waits);
      got.data = rd_data;
      exp      = exp_q.pop_front();
      compare_flag(rd_err, 1'b0, {what, " pslverr"});
      compare_resp(got, exp, what);
    end
  endtask

  initial begin
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] status;
    logic [DATA_W-1:0] used_q [$];
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    rst_n        = 1'b0;
    seed         = 52827;
    next_id      = '0;
    value_errors = 0;
    other_errors = 0;
    foreach (ref_mem[i]) ref_mem[i] = '0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    apb_xfer(1'b0, REG_STATUS, '0, rd_data, rd_err, waits);
    compare_word(rd_data, '0, "STATUS after reset");
    apb_xfer(1'b0, REG_RESP, '0, rd_data, rd_err, waits);
    compare_flag(rd_err, 1'b1, "pslverr of RESP with nothing held");

    for (int i = 0; i < N_RAND; i++) begin
      addr = in_range_addr();
      store_cmd(addr, rand_word());
      used_q.push_back(addr);
    end
    for (int i = 0; i < N_RAND; i++) begin
      addr = (i % 2 == 0) ? used_q[i] : in_range_addr();  // odd ones mostly unwritten
      load_cmd(addr);
      collect_resp("random load");
    end

    for (int i = 0; i < 4; i++) begin
      addr = rand_word();
      addr[MEM_IDX_W + 5 * i] = 1'b1;
      store_cmd(addr, rand_word());
      load_cmd(addr);
      collect_resp("out-of-range load");
      load_cmd(addr & DATA_W'(MEM_WORDS - 1));
      collect_resp("word below a dropped store");
    end

    // one response held, the next one blocks the endpoint, stores pile up
    load_cmd(in_range_addr());
    load_cmd(used_q[0]);
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      store_cmd(DATA_W'(8'h40) + (rand_word() & 32'h3), rand_word());
    end
    status                 = '0;  // stores queued, first load response waiting
    status[STAT_NOT_EMPTY] = 1'b1;
    status[STAT_RESP_HELD] = 1'b1;
    status[STAT_RESP_ERR]  = exp_q[0].err;
    apb_xfer(1'b0, REG_STATUS, '0, rd_data, rd_err, waits);
    compare_word(rd_data, status, "STATUS with the link FIFO full");
    addr = DATA_W'(8'h40) + (rand_word() & 32'h3);
    data = rand_word();
    apb_xfer(1'b1, REG_ADDR, addr, rd_data, rd_err, waits);
    apb_xfer(1'b1, REG_DATA, data, rd_data, rd_err, waits);
    collect_resp("first blocking load");
    apb_xfer(1'b1, REG_CMD, DATA_W'(MC_OP_STORE), rd_data, rd_err, waits);
    ref_mem[addr[MEM_IDX_W-1:0]] = data;
    if (waits == 0) begin
      other_errors++;
      $display("A CMD write into a full link FIFO was not held off");
    end
    collect_resp("second blocking load");
    for (int i = 0; i < 4; i++) begin
      load_cmd(DATA_W'(8'h40 + i));
      collect_resp("load after burst");
    end

    load_cmd(used_q[1]);
    load_cmd(used_q[2]);
    collect_resp("first of two loads");
    collect_resp("second of two loads");

    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: sources.f
verilog/mc_pkg.sv
verilog/mc_io_loader.sv
verilog/mc_link_fifo.sv
verilog/mc_ram_endpoint.sv
verilog/mc_endpoint_top.sv
sim/mc_endpoint_assertions.sv
sim/tb_mc_endpoint.sv

// File: verilog/mc_endpoint_top.sv
module mc_endpoint_top import mc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,

  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [DATA_W-1:0]     pwdata_i,
  output logic [DATA_W-1:0]     prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  mc_req_pkt_s  req;
  logic         req_valid;
  logic         req_ready;

  mc_req_pkt_s  link;
  logic         link_valid;
  logic         link_ready;

  mc_resp_pkt_s resp;
  logic         resp_valid;
  logic         resp_ready;

  logic         fifo_not_empty;

  mc_io_loader u_loader (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .req_o        (req),
    .req_valid_o  (req_valid),
    .req_ready_i  (req_ready),
    .resp_i       (resp),
    .resp_valid_i (resp_valid),
    .resp_ready_o (resp_ready),
    .link_busy_i  (fifo_not_empty)
  );

  mc_link_fifo u_fifo (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .enq_i       (req),
    .enq_valid_i (req_valid),
    .enq_ready_o (req_ready),
    .deq_o       (link),
    .deq_valid_o (link_valid),
    .deq_ready_i (link_ready),
    .not_empty_o (fifo_not_empty)
  );

  mc_ram_endpoint u_endpoint (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_i        (link),
    .req_valid_i  (link_valid),
    .req_ready_o  (link_ready),
    .resp_o       (resp),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready)
  );

endmodule

// File: verilog/mc_io_loader.sv
module mc_io_loader import mc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,

  // host side
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [DATA_W-1:0]     pwdata_i,
  output logic [DATA_W-1:0]     prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,

  // request packets out
  output mc_req_pkt_s           req_o,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,

  // load responses in
  input  mc_resp_pkt_s          resp_i,
  input  logic                  resp_valid_i,
  output logic                  resp_ready_o,

  input  logic                  link_busy_i
);

  logic                 access;
  logic                 wr_addr;
  logic                 wr_data;
  logic                 wr_cmd;
  logic                 rd_resp;
  logic                 req_fire;

  logic [DATA_W-1:0]    addr_q;
  logic [DATA_W-1:0]    data_q;
  logic [LOAD_ID_W-1:0] load_id_q;
  mc_resp_pkt_s         resp_q;
  logic                 resp_held_q;
  mc_op_e               cmd_op;

  assign access  = psel_i & penable_i;
  assign wr_addr = access & pwrite_i & (paddr_i == REG_ADDR);
  assign wr_data = access & pwrite_i & (paddr_i == REG_DATA);
  assign wr_cmd  = access & pwrite_i & (paddr_i == REG_CMD);
  assign rd_resp = access & ~pwrite_i & (paddr_i == REG_RESP);

  assign cmd_op   = mc_op_e'(pwdata_i[0]);
  assign req_fire = req_valid_o & req_ready_i;

  // packet is offered for the whole access phase of a CMD write
  assign req_valid_o = wr_cmd;

  always_comb begin
    req_o.op   = cmd_op;
    req_o.addr = addr_q;
    if (cmd_op == MC_OP_LOAD) begin
      req_o.payload.load_info.pad     = '0;
      req_o.payload.load_info.load_id = load_id_q;
    end else begin
      req_o.payload.data = data_q;
    end
  end

  // host waits on a CMD write until the link buffer takes it
  assign pready_o  = access & (~wr_cmd | req_ready_i);
  assign pslverr_o = rd_resp & ~resp_held_q;

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      REG_ADDR: prdata_o = addr_q;
      REG_DATA: prdata_o = data_q;
      REG_STATUS: begin
        prdata_o[STAT_NOT_EMPTY] = link_busy_i;
        prdata_o[STAT_RESP_HELD] = resp_held_q;
        prdata_o[STAT_RESP_ERR]  = resp_held_q & resp_q.err;
      end
      REG_RESP: if (resp_held_q) prdata_o = resp_q.data;
      default: prdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_addr) addr_q <= pwdata_i;
    if (wr_data) data_q <= pwdata_i;
    if (resp_valid_i && resp_ready_o) resp_q <= resp_i;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      load_id_q <= '0;
    end else if (req_fire && req_o.op == MC_OP_LOAD) begin
      load_id_q <= load_id_q + 1'b1;
    end
  end

  // single holding register, freed by a RESP read
  assign resp_ready_o = ~resp_held_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_held_q <= 1'b0;
    end else if (resp_valid_i && resp_ready_o) begin
      resp_held_q <= 1'b1;
    end else if (rd_resp) begin
      resp_held_q <= 1'b0;
    end
  end

endmodule

// File: verilog/mc_link_fifo.sv
module mc_link_fifo import mc_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,

  input  mc_req_pkt_s enq_i,
  input  logic        enq_valid_i,
  output logic        enq_ready_o,

  output mc_req_pkt_s deq_o,
  output logic        deq_valid_o,
  input  logic        deq_ready_i,

  output logic        not_empty_o
);

  mc_req_pkt_s           mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  enq_fire;
  logic                  deq_fire;

  assign enq_ready_o = (count_q != FIFO_CNT_W'(FIFO_DEPTH));
  assign deq_valid_o = (count_q != '0);
  assign not_empty_o = deq_valid_o;
  assign deq_o       = mem_q[rd_ptr_q];

  assign enq_fire = enq_valid_i & enq_ready_o;
  assign deq_fire = deq_valid_o & deq_ready_i;

  always_ff @(posedge clk) begin
    if (enq_fire) mem_q[wr_ptr_q] <= enq_i;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (deq_fire) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // both at once leaves the count alone
      if (enq_fire && !deq_fire) begin
        count_q <= count_q + 1'b1;
      end else if (deq_fire && !enq_fire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: verilog/mc_pkg.sv
package mc_pkg;

  // bus widths
  localparam int DATA_W     = 32;
  localparam int APB_ADDR_W = 8;

  // endpoint memory
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = 8;   // log2 of MEM_WORDS

  // link buffer
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam int LOAD_ID_W = 12;

  // host register map
  localparam logic [APB_ADDR_W-1:0] REG_ADDR   = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_DATA   = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_CMD    = 8'h08;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] REG_RESP   = 8'h10;

  // STATUS bit positions
  localparam int STAT_NOT_EMPTY = 0;
  localparam int STAT_RESP_HELD = 1;
  localparam int STAT_RESP_ERR  = 2;

  typedef enum logic {
    MC_OP_STORE = 1'b0,
    MC_OP_LOAD  = 1'b1
  } mc_op_e;

  // load view of the payload, tag in the low bits
  typedef struct packed {
    logic [DATA_W-LOAD_ID_W-1:0] pad;
    logic [LOAD_ID_W-1:0]        load_id;
  } mc_load_info_s;

  // store data or load info, selected by the packet op
  typedef union packed {
    logic [DATA_W-1:0] data;
    mc_load_info_s     load_info;
  } mc_payload_u;

  // 65 bits
  typedef struct packed {
    mc_op_e            op;
    logic [DATA_W-1:0] addr;      // word address
    mc_payload_u       payload;
  } mc_req_pkt_s;

  // 45 bits
  typedef struct packed {
    logic [LOAD_ID_W-1:0] load_id;
    logic [DATA_W-1:0]    data;
    logic                 err;
  } mc_resp_pkt_s;

endpackage

// File: verilog/mc_ram_endpoint.sv
module mc_ram_endpoint import mc_pkg::*; (
  input  logic         clk,
  input  logic         rst_n_i,

  input  mc_req_pkt_s  req_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,

  output mc_resp_pkt_s resp_o,
  output logic         resp_valid_o,
  input  logic         resp_ready_i
);

  logic [DATA_W-1:0]    mem_q [MEM_WORDS];
  logic [MEM_IDX_W-1:0] idx;
  logic                 in_range;
  logic                 req_fire;
  logic                 do_store;
  logic                 do_load;
  mc_resp_pkt_s         resp_q;
  logic                 resp_valid_q;

  assign idx      = req_i.addr[MEM_IDX_W-1:0];
  assign in_range = (req_i.addr[DATA_W-1:MEM_IDX_W] == '0);

  // stall the link while a load response waits for the loader
  assign req_ready_o = ~resp_valid_q;
  assign req_fire    = req_valid_i & req_ready_o;
  assign do_store    = req_fire & (req_i.op == MC_OP_STORE);
  assign do_load     = req_fire & (req_i.op == MC_OP_LOAD);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (do_store && in_range) begin
      mem_q[idx] <= req_i.payload.data;
    end
  end

  always_ff @(posedge clk) begin
    if (do_load) begin
      resp_q.load_id <= req_i.payload.load_info.load_id;
      resp_q.data    <= in_range ? mem_q[idx] : '0;
      resp_q.err     <= ~in_range;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (do_load) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule
